/* Makefile */
TOP   = tb_wb_subsys
BUILD = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module wb_subsys_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* design/csr_file.sv */
`timescale 1ns/10ps
`include "wb_consts.svh"

module csr_file (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     csr_re,
    input  logic [`WB_CSR_NUM_W-1:0] csr_num,
    output logic [`WB_XLEN-1:0]      csr_rvalue,

    input  logic                     csr_we,
    input  csr_pkg::csr_op_e         csr_op,
    input  logic [`WB_XLEN-1:0]      csr_wmask,
    input  logic [`WB_XLEN-1:0]      csr_wvalue,

    input  logic                     ex_valid,
    input  exc_pkg::ecode_e          ex_ecode,
    input  logic [`WB_ESUB_W-1:0]    ex_esubcode,
    input  logic [`WB_XLEN-1:0]      ex_pc,
    input  logic                     ertn_valid,

    output exc_pkg::plv_e            cur_plv,
    output logic                     flush_valid,
    output logic [`WB_XLEN-1:0]      flush_target
);

    logic [1:0]              crmd_plv;
    logic [1:0]              prmd_pplv;
    logic [`WB_ECODE_W-1:0]  estat_ecode;
    logic [`WB_ESUB_W-1:0]   estat_esub;
    logic [`WB_XLEN-1:0]     era;
    logic [`WB_XLEN-1:6]     eentry_va;
    logic [`WB_XLEN-1:0]     save0;

    logic [`WB_XLEN-1:0]     old_value;
    logic [`WB_XLEN-1:0]     new_value;
    logic                    sw_write;

    // architectural view of the selected csr.
    always_comb begin
        case (csr_num)
            csr_pkg::CRMD:   old_value = {30'd0, crmd_plv};
            csr_pkg::PRMD:   old_value = {30'd0, prmd_pplv};
            csr_pkg::ESTAT:  old_value = {1'b0, estat_esub, estat_ecode, 16'd0};
            csr_pkg::ERA:    old_value = era;
            csr_pkg::EENTRY: old_value = {eentry_va, 6'd0};
            csr_pkg::SAVE0:  old_value = save0;
            default:         old_value = '0;
        endcase
    end

    assign csr_rvalue = csr_re ? old_value : '0;

    // masked merge of software data into the old value.
    assign new_value = (csr_wvalue & csr_wmask) | (old_value & ~csr_wmask);
    assign sw_write  = csr_we && (csr_op != csr_pkg::CSR_RD);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd_plv    <= exc_pkg::PLV_KERNEL;
            prmd_pplv   <= 2'd0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            eentry_va   <= '0;
            save0       <= '0;
        end else if (ex_valid) begin
            // exception entry.
            prmd_pplv   <= crmd_plv;
            crmd_plv    <= exc_pkg::PLV_KERNEL;
            estat_ecode <= ex_ecode;
            estat_esub  <= ex_esubcode;
            era         <= ex_pc;
        end else if (ertn_valid) begin
            crmd_plv <= prmd_pplv;
        end else if (sw_write) begin
            case (csr_num)
                csr_pkg::CRMD: begin
                    crmd_plv <= new_value[1:0];
                end
                csr_pkg::PRMD: begin
                    prmd_pplv <= new_value[1:0];
                end
                csr_pkg::ESTAT: begin
                    estat_ecode <= new_value[21:16];
                    estat_esub  <= new_value[30:22];
                end
                csr_pkg::ERA: begin
                    era <= new_value;
                end
                csr_pkg::EENTRY: begin
                    eentry_va <= new_value[`WB_XLEN-1:6];
                end
                csr_pkg::SAVE0: begin
                    save0 <= new_value;
                end
                default: begin
                end
            endcase
        end
    end

    assign cur_plv = exc_pkg::plv_e'(crmd_plv);

    // redirect to the handler or back to the saved pc.
    assign flush_valid  = ex_valid | ertn_valid;
    assign flush_target = ex_valid ? {eentry_va, 6'd0} : era;

endmodule

/* design/csr_pkg.sv */
`include "wb_consts.svh"

package csr_pkg;

    // implemented csr numbers, everything else reads as zero.
    typedef enum logic [`WB_CSR_NUM_W-1:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030
    } csr_num_e;

    // csrrd / csrwr / csrxchg.
    typedef enum logic [1:0] {
        CSR_RD   = 2'd0,
        CSR_WR   = 2'd1,
        CSR_XCHG = 2'd2
    } csr_op_e;

endpackage

/* design/exc_pkg.sv */
`include "wb_consts.svh"

package exc_pkg;

    // exception kind carried down the pipe with each instruction.
    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_SYS  = 3'd1,
        EXC_BRK  = 3'd2,
        EXC_ADEF = 3'd3,
        EXC_ADEM = 3'd4,
        EXC_INE  = 3'd5
    } exc_kind_e;

    // architectural ecode as written to estat.
    typedef enum logic [`WB_ECODE_W-1:0] {
        ADE = 6'h08,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d,
        IPE = 6'h0e
    } ecode_e;

    typedef enum logic [1:0] {
        PLV_KERNEL = 2'd0,
        PLV_USER   = 2'd3
    } plv_e;

endpackage

/* design/reg_file.sv */
`timescale 1ns/10ps
`include "wb_consts.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we,
    input  logic [`WB_REG_AW-1:0] waddr,
    input  logic [`WB_XLEN-1:0]   wdata,
    input  logic [`WB_REG_AW-1:0] raddr1,
    input  logic [`WB_REG_AW-1:0] raddr2,
    output logic [`WB_XLEN-1:0]   rdata1,
    output logic [`WB_XLEN-1:0]   rdata2
);

    localparam int NREGS = 1 << `WB_REG_AW;

    logic [`WB_XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, no bypass of same-cycle writes.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// data path width.
`define WB_XLEN 32

// general register address width.
`define WB_REG_AW 5

// csr number width.
`define WB_CSR_NUM_W 14

// estat exception code fields.
`define WB_ECODE_W 6
`define WB_ESUB_W 9

`endif

/* design/wb_stage.sv */
`timescale 1ns/10ps
`include "wb_consts.svh"

module wb_stage (
    input  logic                         clk,
    input  logic                         arst_n,

    input  logic                         mem_valid,
    input  logic [`WB_XLEN-1:0]          mem_pc,
    input  logic [`WB_REG_AW-1:0]        mem_dest,
    input  logic [`WB_XLEN-1:0]          mem_result,
    input  logic                         mem_gr_we,
    input  exc_pkg::exc_kind_e           mem_exc,
    input  logic                         mem_is_ertn,
    input  logic                         mem_op_csr,
    input  logic [`WB_CSR_NUM_W-1:0]     mem_csr_num,
    input  logic [`WB_XLEN-1:0]          mem_csr_wmask,
    input  logic [`WB_REG_AW-1:0]        mem_rj,

    input  exc_pkg::plv_e                cur_plv,
    input  logic [`WB_XLEN-1:0]          csr_rvalue,

    output logic                         rf_we,
    output logic [`WB_REG_AW-1:0]        rf_waddr,
    output logic [`WB_XLEN-1:0]          rf_wdata,

    output logic                         csr_re,
    output logic [`WB_CSR_NUM_W-1:0]     csr_num,
    output logic                         csr_we,
    output csr_pkg::csr_op_e             csr_op,
    output logic [`WB_XLEN-1:0]          csr_wmask,
    output logic [`WB_XLEN-1:0]          csr_wvalue,

    output logic                         ex_valid,
    output exc_pkg::ecode_e              ex_ecode,
    output logic [`WB_ESUB_W-1:0]        ex_esubcode,
    output logic [`WB_XLEN-1:0]          ex_pc,
    output logic                         ertn_valid,

    output logic [`WB_REG_AW-1:0]        fwd_dest,
    output logic [`WB_XLEN-1:0]          fwd_data,
    output logic                         fwd_is_csr,

    output logic [`WB_XLEN-1:0]          debug_wb_pc,
    output logic [3:0]                   debug_wb_rf_we,
    output logic [`WB_REG_AW-1:0]        debug_wb_rf_wnum,
    output logic [`WB_XLEN-1:0]          debug_wb_rf_wdata
);

    logic                     valid;
    logic [`WB_XLEN-1:0]      r_pc;
    logic [`WB_REG_AW-1:0]    r_dest;
    logic [`WB_XLEN-1:0]      r_result;
    logic                     r_gr_we;
    exc_pkg::exc_kind_e       r_exc;
    logic                     r_is_ertn;
    logic                     r_op_csr;
    logic [`WB_CSR_NUM_W-1:0] r_csr_num;
    logic [`WB_XLEN-1:0]      r_csr_wmask;
    logic [`WB_REG_AW-1:0]    r_rj;
    logic                     ertn_priv_fault;
    logic                     flush;

    // younger strobe is dropped when the current instruction flushes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= mem_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            r_pc        <= mem_pc;
            r_dest      <= mem_dest;
            r_result    <= mem_result;
            r_gr_we     <= mem_gr_we;
            r_exc       <= mem_exc;
            r_is_ertn   <= mem_is_ertn;
            r_op_csr    <= mem_op_csr;
            r_csr_num   <= mem_csr_num;
            r_csr_wmask <= mem_csr_wmask;
            r_rj        <= mem_rj;
        end
    end

    // ertn outside kernel mode traps.
    assign ertn_priv_fault = r_is_ertn && (cur_plv != exc_pkg::PLV_KERNEL);

    assign ex_valid   = valid && ((r_exc != exc_pkg::EXC_NONE) || ertn_priv_fault);
    assign ertn_valid = valid && r_is_ertn && (r_exc == exc_pkg::EXC_NONE)
                        && (cur_plv == exc_pkg::PLV_KERNEL);
    assign flush      = ex_valid | ertn_valid;
    assign ex_pc      = r_pc;

    always_comb begin
        case (r_exc)
            exc_pkg::EXC_SYS:  ex_ecode = exc_pkg::SYS;
            exc_pkg::EXC_BRK:  ex_ecode = exc_pkg::BRK;
            exc_pkg::EXC_ADEF: ex_ecode = exc_pkg::ADE;
            exc_pkg::EXC_ADEM: ex_ecode = exc_pkg::ADE;
            exc_pkg::EXC_INE:  ex_ecode = exc_pkg::INE;
            default:           ex_ecode = exc_pkg::IPE;
        endcase
    end

    assign ex_esubcode = (r_exc == exc_pkg::EXC_ADEM) ? `WB_ESUB_W'(1) : '0;

    // rj selects the csr instruction flavour.
    always_comb begin
        if (r_rj == `WB_REG_AW'(0)) begin
            csr_op = csr_pkg::CSR_RD;
        end else if (r_rj == `WB_REG_AW'(1)) begin
            csr_op = csr_pkg::CSR_WR;
        end else begin
            csr_op = csr_pkg::CSR_XCHG;
        end
    end

    assign csr_re     = valid && r_op_csr;
    assign csr_num    = r_csr_num;
    assign csr_we     = csr_re && (csr_op != csr_pkg::CSR_RD) && !ex_valid;
    assign csr_wmask  = (csr_op == csr_pkg::CSR_WR) ? '1 : r_csr_wmask;
    assign csr_wvalue = r_result;

    // csr instructions return the old csr value.
    assign rf_we    = valid && r_gr_we && !ex_valid;
    assign rf_waddr = r_dest;
    assign rf_wdata = csr_re ? csr_rvalue : r_result;

    assign fwd_dest   = valid ? r_dest : '0;
    assign fwd_data   = rf_wdata;
    assign fwd_is_csr = csr_re;

    assign debug_wb_pc       = r_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* design/wb_subsys_top.sv */
`timescale 1ns/10ps
`include "wb_consts.svh"

module wb_subsys_top (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     mem_valid,
    input  logic [`WB_XLEN-1:0]      mem_pc,
    input  logic [`WB_REG_AW-1:0]    mem_dest,
    input  logic [`WB_XLEN-1:0]      mem_result,
    input  logic                     mem_gr_we,
    input  exc_pkg::exc_kind_e       mem_exc,
    input  logic                     mem_is_ertn,
    input  logic                     mem_op_csr,
    input  logic [`WB_CSR_NUM_W-1:0] mem_csr_num,
    input  logic [`WB_XLEN-1:0]      mem_csr_wmask,
    input  logic [`WB_REG_AW-1:0]    mem_rj,

    input  logic [`WB_REG_AW-1:0]    rf_raddr1,
    input  logic [`WB_REG_AW-1:0]    rf_raddr2,
    output logic [`WB_XLEN-1:0]      rf_rdata1,
    output logic [`WB_XLEN-1:0]      rf_rdata2,

    output logic [`WB_REG_AW-1:0]    fwd_dest,
    output logic [`WB_XLEN-1:0]      fwd_data,
    output logic                     fwd_is_csr,

    output logic                     flush_valid,
    output logic [`WB_XLEN-1:0]      flush_target,
    output exc_pkg::plv_e            cur_plv,

    output logic [`WB_XLEN-1:0]      debug_wb_pc,
    output logic [3:0]               debug_wb_rf_we,
    output logic [`WB_REG_AW-1:0]    debug_wb_rf_wnum,
    output logic [`WB_XLEN-1:0]      debug_wb_rf_wdata
);

    logic                     rf_we;
    logic [`WB_REG_AW-1:0]    rf_waddr;
    logic [`WB_XLEN-1:0]      rf_wdata;
    logic                     csr_re;
    logic [`WB_CSR_NUM_W-1:0] csr_num;
    logic [`WB_XLEN-1:0]      csr_rvalue;
    logic                     csr_we;
    csr_pkg::csr_op_e         csr_op;
    logic [`WB_XLEN-1:0]      csr_wmask;
    logic [`WB_XLEN-1:0]      csr_wvalue;
    logic                     ex_valid;
    exc_pkg::ecode_e          ex_ecode;
    logic [`WB_ESUB_W-1:0]    ex_esubcode;
    logic [`WB_XLEN-1:0]      ex_pc;
    logic                     ertn_valid;

    wb_stage u_wb_stage (
        .clk               (clk),
        .arst_n            (arst_n),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_dest          (mem_dest),
        .mem_result        (mem_result),
        .mem_gr_we         (mem_gr_we),
        .mem_exc           (mem_exc),
        .mem_is_ertn       (mem_is_ertn),
        .mem_op_csr        (mem_op_csr),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_wmask     (mem_csr_wmask),
        .mem_rj            (mem_rj),
        .cur_plv           (cur_plv),
        .csr_rvalue        (csr_rvalue),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .csr_re            (csr_re),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_op            (csr_op),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .ex_valid          (ex_valid),
        .ex_ecode          (ex_ecode),
        .ex_esubcode       (ex_esubcode),
        .ex_pc             (ex_pc),
        .ertn_valid        (ertn_valid),
        .fwd_dest          (fwd_dest),
        .fwd_data          (fwd_data),
        .fwd_is_csr        (fwd_is_csr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .arst_n       (arst_n),
        .csr_re       (csr_re),
        .csr_num      (csr_num),
        .csr_rvalue   (csr_rvalue),
        .csr_we       (csr_we),
        .csr_op       (csr_op),
        .csr_wmask    (csr_wmask),
        .csr_wvalue   (csr_wvalue),
        .ex_valid     (ex_valid),
        .ex_ecode     (ex_ecode),
        .ex_esubcode  (ex_esubcode),
        .ex_pc        (ex_pc),
        .ertn_valid   (ertn_valid),
        .cur_plv      (cur_plv),
        .flush_valid  (flush_valid),
        .flush_target (flush_target)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

/* filelist.f */
+incdir+design
design/exc_pkg.sv
design/csr_pkg.sv
design/wb_stage.sv
design/csr_file.sv
design/reg_file.sv
design/wb_subsys_top.sv
sim/tb_wb_subsys.sv

/* sim/tb_wb_subsys.sv */
`timescale 1ns/10ps
`include "wb_consts.svh"

module tb_wb_subsys;

    logic                     clk;
    logic                     arst_n;
    logic                     mem_valid;
    logic [`WB_XLEN-1:0]      mem_pc;
    logic [`WB_REG_AW-1:0]    mem_dest;
    logic [`WB_XLEN-1:0]      mem_result;
    logic                     mem_gr_we;
    exc_pkg::exc_kind_e       mem_exc;
    logic                     mem_is_ertn;
    logic                     mem_op_csr;
    logic [`WB_CSR_NUM_W-1:0] mem_csr_num;
    logic [`WB_XLEN-1:0]      mem_csr_wmask;
    logic [`WB_REG_AW-1:0]    mem_rj;
    logic [`WB_REG_AW-1:0]    rf_raddr1;
    logic [`WB_REG_AW-1:0]    rf_raddr2;
    logic [`WB_XLEN-1:0]      rf_rdata1;
    logic [`WB_XLEN-1:0]      rf_rdata2;
    logic [`WB_REG_AW-1:0]    fwd_dest;
    logic [`WB_XLEN-1:0]      fwd_data;
    logic                     fwd_is_csr;
    logic                     flush_valid;
    logic [`WB_XLEN-1:0]      flush_target;
    exc_pkg::plv_e            cur_plv;
    logic [`WB_XLEN-1:0]      debug_wb_pc;
    logic [3:0]               debug_wb_rf_we;
    logic [`WB_REG_AW-1:0]    debug_wb_rf_wnum;
    logic [`WB_XLEN-1:0]      debug_wb_rf_wdata;

    // reference model of the architectural state.
    logic [`WB_XLEN-1:0]      m_regs [32];
    logic [`WB_XLEN-1:0]      m_crmd;
    logic [`WB_XLEN-1:0]      m_prmd;
    logic [`WB_XLEN-1:0]      m_estat;
    logic [`WB_XLEN-1:0]      m_era;
    logic [`WB_XLEN-1:0]      m_eentry;
    logic [`WB_XLEN-1:0]      m_save0;

    // copy of the instruction held in write-back.
    logic                     wb_valid;
    logic [`WB_XLEN-1:0]      wb_pc;
    logic [`WB_REG_AW-1:0]    wb_dest;
    logic [`WB_XLEN-1:0]      wb_result;
    logic                     wb_gr_we;
    exc_pkg::exc_kind_e       wb_exc;
    logic                     wb_is_ertn;
    logic                     wb_op_csr;
    logic [`WB_CSR_NUM_W-1:0] wb_csr_num;
    logic [`WB_XLEN-1:0]      wb_csr_wmask;
    logic [`WB_REG_AW-1:0]    wb_rj;

    logic                     exp_flush;
    logic [`WB_REG_AW-1:0]    last_dest;
    logic                     saw_flush;
    logic                     saw_write;
    logic [`WB_XLEN-1:0]      next_pc;
    logic [`WB_XLEN-1:0]      rnd;
    integer                   seed;
    int                       mismatches;
    int                       timeouts;

    exc_pkg::exc_kind_e kinds [5] = '{exc_pkg::EXC_SYS, exc_pkg::EXC_BRK, exc_pkg::EXC_ADEF,
                                      exc_pkg::EXC_ADEM, exc_pkg::EXC_INE};

    wb_subsys_top UUT (.*);

    always #20 clk = ~clk;

    task automatic check_val(input string name, input logic [`WB_XLEN-1:0] got,
                             input logic [`WB_XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    function automatic logic [`WB_XLEN-1:0] model_csr_read(input logic [`WB_CSR_NUM_W-1:0] num);
        logic [`WB_XLEN-1:0] value;
        case (num)
            csr_pkg::CRMD:   value = m_crmd;
            csr_pkg::PRMD:   value = m_prmd;
            csr_pkg::ESTAT:  value = m_estat;
            csr_pkg::ERA:    value = m_era;
            csr_pkg::EENTRY: value = m_eentry;
            csr_pkg::SAVE0:  value = m_save0;
            default:         value = '0;
        endcase
        return value;
    endfunction

    task automatic model_csr_write(input logic [`WB_CSR_NUM_W-1:0] num,
                                   input logic [`WB_XLEN-1:0] value,
                                   input logic [`WB_XLEN-1:0] mask);
        logic [`WB_XLEN-1:0] merged;
        merged = (value & mask) | (model_csr_read(num) & ~mask);
        case (num)
            csr_pkg::CRMD:   m_crmd = merged & 32'h0000_0003;
            csr_pkg::PRMD:   m_prmd = merged & 32'h0000_0003;
            csr_pkg::ESTAT:  m_estat = merged & 32'h7fff_0000;
            csr_pkg::ERA:    m_era = merged;
            csr_pkg::EENTRY: m_eentry = merged & ~32'h0000_003f;
            csr_pkg::SAVE0:  m_save0 = merged;
            default:         m_save0 = m_save0;
        endcase
    endtask

    // estat image for an exception; no kind means a privileged ertn.
    function automatic logic [`WB_XLEN-1:0] estat_for(input exc_pkg::exc_kind_e kind);
        logic [`WB_ECODE_W-1:0] code;
        logic [`WB_ESUB_W-1:0]  sub;
        sub = '0;
        case (kind)
            exc_pkg::EXC_SYS:  code = exc_pkg::SYS;
            exc_pkg::EXC_BRK:  code = exc_pkg::BRK;
            exc_pkg::EXC_ADEF: code = exc_pkg::ADE;
            exc_pkg::EXC_ADEM: code = exc_pkg::ADE;
            exc_pkg::EXC_INE:  code = exc_pkg::INE;
            default:           code = exc_pkg::IPE;
        endcase
        if (kind == exc_pkg::EXC_ADEM)
            sub = `WB_ESUB_W'(1);
        return {1'b0, sub, code, 16'h0000};
    endfunction

    task automatic check_wb();
        logic                ex;
        logic                ertn;
        logic                exp_we;
        logic [`WB_XLEN-1:0] exp_wdata;
        logic [`WB_XLEN-1:0] mask;
        exp_flush = 1'b0;
        check_val("cur_plv", `WB_XLEN'(cur_plv), m_crmd);
        check_val("rf_rdata1", rf_rdata1, m_regs[rf_raddr1]);
        check_val("rf_rdata2", rf_rdata2, m_regs[rf_raddr2]);
        if (flush_valid)
            saw_flush = 1'b1;
        if (debug_wb_rf_we != 4'h0)
            saw_write = 1'b1;
        if (!wb_valid) begin
            check_val("debug_wb_rf_we", `WB_XLEN'(debug_wb_rf_we), '0);
            check_val("flush_valid", `WB_XLEN'(flush_valid), '0);
            check_val("fwd_dest", `WB_XLEN'(fwd_dest), '0);
            check_val("fwd_is_csr", `WB_XLEN'(fwd_is_csr), '0);
        end else begin
            ertn = wb_is_ertn && (wb_exc == exc_pkg::EXC_NONE) && (m_crmd[1:0] == 2'd0);
            ex = (wb_exc != exc_pkg::EXC_NONE) || (wb_is_ertn && (m_crmd[1:0] != 2'd0));
            exp_we = wb_gr_we && !ex;
            exp_wdata = wb_op_csr ? model_csr_read(wb_csr_num) : wb_result;
            check_val("debug_wb_pc", debug_wb_pc, wb_pc);
            check_val("debug_wb_rf_we", `WB_XLEN'(debug_wb_rf_we), `WB_XLEN'({4{exp_we}}));
            if (exp_we) begin
                check_val("debug_wb_rf_wnum", `WB_XLEN'(debug_wb_rf_wnum), `WB_XLEN'(wb_dest));
                check_val("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata);
            end
            check_val("fwd_dest", `WB_XLEN'(fwd_dest), `WB_XLEN'(wb_dest));
            check_val("fwd_data", fwd_data, exp_wdata);
            check_val("fwd_is_csr", `WB_XLEN'(fwd_is_csr), `WB_XLEN'(wb_op_csr));
            check_val("flush_valid", `WB_XLEN'(flush_valid), `WB_XLEN'(ex || ertn));
            if (ex || ertn)
                check_val("flush_target", flush_target, ex ? m_eentry : m_era);
            if (ex) begin
                m_prmd = m_crmd;
                m_crmd = '0;
                m_estat = estat_for(wb_exc);
                m_era = wb_pc;
            end else if (ertn) begin
                m_crmd = m_prmd;
            end else if (wb_op_csr && (wb_rj != 5'd0)) begin
                mask = (wb_rj == 5'd1) ? '1 : wb_csr_wmask;
                model_csr_write(wb_csr_num, wb_result, mask);
            end
            if (exp_we && (wb_dest != 5'd0))
                m_regs[wb_dest] = exp_wdata;
            exp_flush = ex || ertn;
            last_dest = wb_dest;
        end
    endtask

    // check at the falling edge, then inputs change just after the rising edge.
    task automatic cycle();
        @(negedge clk);
        check_wb();
        wb_valid = mem_valid && !exp_flush;
        wb_pc = mem_pc;
        wb_dest = mem_dest;
        wb_result = mem_result;
        wb_gr_we = mem_gr_we;
        wb_exc = mem_exc;
        wb_is_ertn = mem_is_ertn;
        wb_op_csr = mem_op_csr;
        wb_csr_num = mem_csr_num;
        wb_csr_wmask = mem_csr_wmask;
        wb_rj = mem_rj;
        @(posedge clk);
        #2;
        mem_valid = 1'b0;
        rf_raddr1 = last_dest;
        rnd = $random(seed);
        rf_raddr2 = rnd[4:0];
    endtask

    task automatic step_until(input logic for_flush, input int limit);
        int n;
        n = 0;
        saw_flush = 1'b0;
        saw_write = 1'b0;
        while (!(for_flush ? saw_flush : saw_write) && (n < limit)) begin
            cycle();
            n++;
        end
        if (!(for_flush ? saw_flush : saw_write)) begin
            $display("timeout: no %s seen within %0d cycles", for_flush ? "flush" : "write",
                     limit);
            timeouts++;
        end
    endtask

    task automatic drive_common(input logic gr_we, input logic [`WB_REG_AW-1:0] dest,
                                input logic [`WB_XLEN-1:0] result);
        mem_valid = 1'b1;
        mem_pc = next_pc;
        mem_dest = dest;
        mem_result = result;
        mem_gr_we = gr_we;
        mem_exc = exc_pkg::EXC_NONE;
        mem_is_ertn = 1'b0;
        mem_op_csr = 1'b0;
        mem_csr_num = '0;
        mem_csr_wmask = '0;
        mem_rj = '0;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drive_csr(input logic [`WB_CSR_NUM_W-1:0] num,
                             input logic [`WB_REG_AW-1:0] rj,
                             input logic [`WB_XLEN-1:0] value,
                             input logic [`WB_XLEN-1:0] wmask);
        logic [`WB_XLEN-1:0] r;
        r = $random(seed);
        drive_common(1'b1, r[4:0] | 5'd1, value);
        mem_op_csr = 1'b1;
        mem_csr_num = num;
        mem_rj = rj;
        mem_csr_wmask = wmask;
    endtask

    task automatic set_csr(input logic [`WB_CSR_NUM_W-1:0] num, input logic [`WB_XLEN-1:0] v);
        drive_csr(num, 5'd1, v, '0);
        cycle();
    endtask

    // write, read, exchange, read.
    task automatic csr_sequence(input logic [`WB_CSR_NUM_W-1:0] num);
        logic [`WB_XLEN-1:0] v;
        logic [`WB_XLEN-1:0] m;
        v = $random(seed);
        set_csr(num, v | 32'h0000_003f);
        drive_csr(num, 5'd0, '0, '0);
        cycle();
        v = $random(seed);
        m = $random(seed);
        drive_csr(num, 5'd7, v, m);
        cycle();
        drive_csr(num, 5'd0, '0, '0);
        cycle();
    endtask

    task automatic raise_exception(input exc_pkg::exc_kind_e kind);
        logic [`WB_XLEN-1:0] r;
        r = $random(seed);
        drive_common(1'b1, r[4:0] | 5'd1, $random(seed));
        mem_exc = kind;
        cycle();
        // younger strobe lands in the flush cycle.
        drive_common(1'b1, r[4:0] | 5'd1, $random(seed));
        step_until(1'b1, 4);
        cycle();
    endtask

    task automatic raise_ertn();
        drive_common(1'b0, '0, '0);
        mem_is_ertn = 1'b1;
        step_until(1'b1, 4);
        cycle();
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        seed = 56;
        mismatches = 0;
        timeouts = 0;
        next_pc = 32'h1c00_0000;
        drive_common(1'b0, '0, '0);
        mem_valid = 1'b0;
        rf_raddr1 = '0;
        rf_raddr2 = '0;
        wb_valid = 1'b0;
        exp_flush = 1'b0;
        last_dest = '0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        m_crmd = '0;
        m_prmd = '0;
        m_estat = '0;
        m_era = '0;
        m_eentry = '0;
        m_save0 = '0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        cycle();
        cycle();

        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            drive_common(1'b1, (i == 3) ? 5'd0 : rnd[4:0], $random(seed));
            step_until(1'b0, 4);
            cycle();
        end

        // back-to-back stream.
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            drive_common(1'b1, rnd[4:0], $random(seed));
            cycle();
        end
        cycle();

        csr_sequence(csr_pkg::SAVE0);
        csr_sequence(csr_pkg::EENTRY);
        csr_sequence(14'h123);
        cycle();

        for (int i = 0; i < 5; i++) begin
            if (i % 2 == 1)
                set_csr(csr_pkg::CRMD, 32'd3);
            raise_exception(kinds[i]);
            drive_csr(csr_pkg::ERA, 5'd0, '0, '0);
            cycle();
            drive_csr(csr_pkg::ESTAT, 5'd0, '0, '0);
            cycle();
            drive_csr(csr_pkg::PRMD, 5'd0, '0, '0);
            cycle();
            cycle();
        end

        // ertn from user mode traps, from kernel mode it returns.
        set_csr(csr_pkg::PRMD, 32'd3);
        set_csr(csr_pkg::CRMD, 32'd3);
        raise_ertn();
        set_csr(csr_pkg::PRMD, 32'd3);
        set_csr(csr_pkg::ERA, $random(seed));
        raise_ertn();
        cycle();
        set_csr(csr_pkg::CRMD, 32'd0);
        cycle();

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if ((mismatches == 0) && (timeouts == 0))
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
